//--- common/i3c_target_pkg.sv
// I3C SDR target shared types for bus events, data streams and address setup
`default_nettype none

package i3c_target_pkg;

  // One bus line with its pre-detected edges and levels
  typedef struct packed {
    logic value;
    logic pos_edge;
    logic neg_edge;
    logic stable_high;
    logic stable_low;
  } line_state_t;

  typedef struct packed {
    logic        start_det;
    logic        rstart_det;
    logic        stop_det;
    line_state_t scl;
    line_state_t sda;
  } bus_state_t;

  // Received write byte
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
  } rx_item_t;

  // Byte to send on a private read
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } tx_item_t;

  typedef struct packed {
    logic [6:0] sta_addr;
    logic       sta_addr_valid;
  } addr_cfg_t;

  // SDA transitions with SCL low that open a Target Reset Pattern
  localparam int ResetPatternEdges = 14;

endpackage

`default_nettype wire

//--- target/i3c_target_fsm.sv
// I3C target transaction sequencer for address, ACK, private writes and reads
`timescale 1ns/100ps
`default_nettype none

module i3c_target_fsm (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  i3c_target_pkg::bus_state_t bus_i,
  input  i3c_target_pkg::addr_cfg_t  cfg_i,
  output logic                       rx_req_bit_o,
  output logic                       rx_req_byte_o,
  input  logic                       rx_done_i,
  input  logic [7:0]                 rx_data_i,
  output logic                       tx_req_bit_o,
  output logic                       tx_req_byte_o,
  output logic [7:0]                 tx_value_o,
  output logic                       tx_sel_od_pp_o,
  input  logic                       tx_done_i,
  output logic                       rx_valid_o,
  output i3c_target_pkg::rx_item_t   rx_item_o,
  input  logic                       tx_valid_i,
  input  i3c_target_pkg::tx_item_t   tx_item_i,
  output logic                       tx_ready_o,
  output logic [7:0]                 bus_addr_o,
  output logic                       bus_addr_valid_o
);

  typedef enum logic [2:0] {
    Idle,
    Addr,
    Ack,
    WrData,
    WrTbit,
    RdData,
    RdTbit,
    WaitStop
  } state_e;

  state_e     state_q;
  state_e     state_d;
  logic [7:0] wr_data_q;
  logic       tx_last_q;
  logic       rnw_q;
  logic       addr_match;
  logic       addr_hit;
  logic       load_byte;

  // Upper 7 bits hold the address and bit 0 is RnW
  assign addr_match = cfg_i.sta_addr_valid && (rx_data_i[7:1] == cfg_i.sta_addr);
  assign addr_hit   = (state_q == Addr) && rx_done_i && addr_match;

  always_comb begin
    state_d        = state_q;
    rx_req_bit_o   = 1'b0;
    rx_req_byte_o  = 1'b0;
    tx_req_bit_o   = 1'b0;
    tx_req_byte_o  = 1'b0;
    tx_value_o     = 8'hff;
    tx_sel_od_pp_o = 1'b0;
    tx_ready_o     = 1'b0;
    load_byte      = 1'b0;

    if (bus_i.start_det || bus_i.rstart_det || bus_i.stop_det) begin
      // Released bit in open drain cuts a read short
      if (state_q == RdData || state_q == RdTbit) tx_req_bit_o = 1'b1;
      if (bus_i.stop_det) begin
        state_d = Idle;
      end else begin
        state_d       = Addr;
        rx_req_byte_o = 1'b1;
      end
    end else begin
      unique case (state_q)
        Addr: begin
          if (rx_done_i) begin
            // A read with nothing queued is NACKed
            if (addr_match && (!rx_data_i[0] || tx_valid_i)) begin
              state_d      = Ack;
              tx_req_bit_o = 1'b1;
              tx_value_o   = 8'h00;
            end else begin
              state_d = WaitStop;
            end
          end
        end
        Ack: begin
          if (tx_done_i) begin
            if (!rnw_q) begin
              state_d       = WrData;
              rx_req_byte_o = 1'b1;
            end else if (tx_valid_i) begin
              state_d   = RdData;
              load_byte = 1'b1;
            end else begin
              state_d = WaitStop;
            end
          end
        end
        WrData: begin
          if (rx_done_i) begin
            state_d      = WrTbit;
            rx_req_bit_o = 1'b1;
          end
        end
        WrTbit: begin
          if (rx_done_i) begin
            state_d       = WrData;
            rx_req_byte_o = 1'b1;
          end
        end
        RdData: begin
          if (tx_done_i) begin
            state_d        = RdTbit;
            tx_req_bit_o   = 1'b1;
            tx_value_o     = {7'b0, ~tx_last_q};
            tx_sel_od_pp_o = 1'b1;
          end
        end
        RdTbit: begin
          if (tx_done_i) begin
            if (!tx_last_q && tx_valid_i) begin
              state_d   = RdData;
              load_byte = 1'b1;
            end else begin
              state_d = WaitStop;
            end
          end
        end
        default: ;
      endcase
    end

    if (load_byte) begin
      tx_ready_o     = 1'b1;
      tx_req_byte_o  = 1'b1;
      tx_value_o     = tx_item_i.data;
      tx_sel_od_pp_o = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= Idle;
      bus_addr_valid_o <= 1'b0;
      rx_valid_o       <= 1'b0;
      rx_item_o        <= '0;
    end else begin
      state_q          <= state_d;
      bus_addr_valid_o <= addr_hit;
      rx_valid_o       <= (state_q == WrTbit) && (state_d == WrData);
      if ((state_q == WrTbit) && (state_d == WrData)) begin
        rx_item_o.data       <= wr_data_q;
        // Data byte plus T-bit must hold an odd number of ones
        rx_item_o.parity_err <= ~^{wr_data_q, rx_data_i[0]};
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == Addr) && rx_done_i) rnw_q <= rx_data_i[0];
    if (addr_hit) bus_addr_o <= rx_data_i;
    if ((state_q == WrData) && rx_done_i) wr_data_q <= rx_data_i;
    if (load_byte) tx_last_q <= tx_item_i.last;
  end

endmodule

`default_nettype wire

//--- hdl/bus_rx_flow.sv
// SDA sampler that collects one bit or one byte on SCL rising edges
`timescale 1ns/100ps
`default_nettype none

module bus_rx_flow (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       scl_posedge_i,
  input  logic       sda_i,
  input  logic       req_bit_i,
  input  logic       req_byte_i,
  output logic [7:0] data_o,
  output logic       done_o
);

  logic [3:0] cnt_q;
  logic       sample;

  // A fresh request restarts the count
  assign sample = scl_posedge_i && (cnt_q != 4'd0) && !(req_bit_i || req_byte_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q  <= 4'd0;
      done_o <= 1'b0;
    end else begin
      if (req_byte_i) cnt_q <= 4'd8;
      else if (req_bit_i) cnt_q <= 4'd1;
      else if (sample) cnt_q <= cnt_q - 4'd1;
      done_o <= sample && (cnt_q == 4'd1);
    end
  end

  // MSB arrives first
  always_ff @(posedge clk_i) begin
    if (sample) data_o <= {data_o[6:0], sda_i};
  end

endmodule

`default_nettype wire

//--- hdl/bus_tx_flow.sv
// SDA driver that shifts out one bit or one byte on SCL falling edges
`timescale 1ns/100ps
`default_nettype none

module bus_tx_flow (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       scl_negedge_i,
  input  logic       req_bit_i,
  input  logic       req_byte_i,
  input  logic [7:0] value_i,
  input  logic       sel_od_pp_i,
  output logic       done_o,
  output logic       sda_o,
  output logic       sel_od_pp_o
);

  logic [7:0] shift_q;
  logic [3:0] cnt_q;
  logic       sel_q;
  logic       active_q;
  logic       req;
  logic [7:0] req_value;
  logic [3:0] req_cnt;

  assign req       = req_bit_i | req_byte_i;
  // Single bit requests move bit 0 into the MSB slot
  assign req_value = req_byte_i ? value_i : {value_i[0], 7'b0};
  assign req_cnt   = req_byte_i ? 4'd8 : 4'd1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shift_q     <= 8'h00;
      cnt_q       <= 4'd0;
      sel_q       <= 1'b0;
      active_q    <= 1'b0;
      done_o      <= 1'b0;
      sda_o       <= 1'b1;
      sel_od_pp_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (req) begin
        sel_q <= sel_od_pp_i;
        if (done_o) begin
          // Previous bit ended on the last falling edge so the next one starts at once
          sda_o       <= req_value[7];
          sel_od_pp_o <= sel_od_pp_i;
          shift_q     <= {req_value[6:0], 1'b0};
          cnt_q       <= req_cnt - 4'd1;
          active_q    <= 1'b1;
        end else begin
          sda_o       <= 1'b1;
          sel_od_pp_o <= 1'b0;
          shift_q     <= req_value;
          cnt_q       <= req_cnt;
          active_q    <= 1'b0;
        end
      end else if (scl_negedge_i) begin
        if (cnt_q != 4'd0) begin
          sda_o       <= shift_q[7];
          sel_od_pp_o <= sel_q;
          shift_q     <= {shift_q[6:0], 1'b0};
          cnt_q       <= cnt_q - 4'd1;
          active_q    <= 1'b1;
        end else if (active_q) begin
          // Release the line after the last bit
          sda_o       <= 1'b1;
          sel_od_pp_o <= 1'b0;
          active_q    <= 1'b0;
          done_o      <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/target_reset_monitor.sv
// Target Reset Pattern detector with peripheral and escalated reset levels
`timescale 1ns/100ps
`default_nettype none

module target_reset_monitor (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  i3c_target_pkg::bus_state_t bus_i,
  input  logic                       addr_match_i,
  input  logic                       peripheral_reset_done_i,
  output logic                       peripheral_reset_o,
  output logic                       escalated_reset_o
);

  import i3c_target_pkg::*;

  logic [3:0] edge_cnt_q;
  logic       edges_ok_q;
  logic       rstart_ok_q;
  logic       armed_q;
  logic       scl_edge;
  logic       sda_edge;
  logic       pattern_det;

  assign scl_edge    = bus_i.scl.pos_edge | bus_i.scl.neg_edge;
  assign sda_edge    = bus_i.sda.pos_edge | bus_i.sda.neg_edge;
  assign pattern_det = rstart_ok_q & bus_i.stop_det;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      edge_cnt_q  <= 4'd0;
      edges_ok_q  <= 1'b0;
      rstart_ok_q <= 1'b0;
    end else begin
      // SDA toggles only count inside one SCL low phase
      if (scl_edge) edge_cnt_q <= 4'd0;
      else if (sda_edge && bus_i.scl.stable_low &&
               edge_cnt_q != 4'(ResetPatternEdges)) edge_cnt_q <= edge_cnt_q + 4'd1;

      if (bus_i.stop_det || bus_i.start_det || bus_i.scl.neg_edge) begin
        edges_ok_q  <= 1'b0;
        rstart_ok_q <= 1'b0;
      end else begin
        if (edge_cnt_q == 4'(ResetPatternEdges)) edges_ok_q <= 1'b1;
        if (bus_i.rstart_det && edges_ok_q) rstart_ok_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q            <= 1'b0;
      peripheral_reset_o <= 1'b0;
      escalated_reset_o  <= 1'b0;
    end else begin
      if (pattern_det) begin
        // Second pattern in a row escalates
        if (armed_q) escalated_reset_o <= 1'b1;
        else peripheral_reset_o <= 1'b1;
        armed_q <= 1'b1;
      end else if (addr_match_i) begin
        armed_q <= 1'b0;
      end
      if (peripheral_reset_done_i) peripheral_reset_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/i3c_target_top.sv
// I3C SDR target core that joins the transaction FSM, the bit flows and the reset monitor
`timescale 1ns/100ps
`default_nettype none

module i3c_target_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  i3c_target_pkg::bus_state_t   bus_i,
  input  i3c_target_pkg::addr_cfg_t    cfg_i,
  output logic                         sda_o,
  output logic                         sel_od_pp_o,
  output logic                         rx_valid_o,
  output i3c_target_pkg::rx_item_t     rx_item_o,
  input  logic                         tx_valid_i,
  input  i3c_target_pkg::tx_item_t     tx_item_i,
  output logic                         tx_ready_o,
  output logic [7:0]                   bus_addr_o,
  output logic                         bus_addr_valid_o,
  output logic                         peripheral_reset_o,
  input  logic                         peripheral_reset_done_i,
  output logic                         escalated_reset_o
);

  logic       rx_req_bit;
  logic       rx_req_byte;
  logic       rx_done;
  logic [7:0] rx_data;
  logic       tx_req_bit;
  logic       tx_req_byte;
  logic [7:0] tx_value;
  logic       tx_sel_od_pp;
  logic       tx_done;

  i3c_target_fsm i3c_target_fsm_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .bus_i            (bus_i),
    .cfg_i            (cfg_i),
    .rx_req_bit_o     (rx_req_bit),
    .rx_req_byte_o    (rx_req_byte),
    .rx_done_i        (rx_done),
    .rx_data_i        (rx_data),
    .tx_req_bit_o     (tx_req_bit),
    .tx_req_byte_o    (tx_req_byte),
    .tx_value_o       (tx_value),
    .tx_sel_od_pp_o   (tx_sel_od_pp),
    .tx_done_i        (tx_done),
    .rx_valid_o       (rx_valid_o),
    .rx_item_o        (rx_item_o),
    .tx_valid_i       (tx_valid_i),
    .tx_item_i        (tx_item_i),
    .tx_ready_o       (tx_ready_o),
    .bus_addr_o       (bus_addr_o),
    .bus_addr_valid_o (bus_addr_valid_o)
  );

  bus_rx_flow bus_rx_flow_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .scl_posedge_i (bus_i.scl.pos_edge),
    .sda_i         (bus_i.sda.value),
    .req_bit_i     (rx_req_bit),
    .req_byte_i    (rx_req_byte),
    .data_o        (rx_data),
    .done_o        (rx_done)
  );

  bus_tx_flow bus_tx_flow_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .scl_negedge_i (bus_i.scl.neg_edge),
    .req_bit_i     (tx_req_bit),
    .req_byte_i    (tx_req_byte),
    .value_i       (tx_value),
    .sel_od_pp_i   (tx_sel_od_pp),
    .done_o        (tx_done),
    .sda_o         (sda_o),
    .sel_od_pp_o   (sel_od_pp_o)
  );

  target_reset_monitor target_reset_monitor_inst (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .bus_i                   (bus_i),
    .addr_match_i            (bus_addr_valid_o),
    .peripheral_reset_done_i (peripheral_reset_done_i),
    .peripheral_reset_o      (peripheral_reset_o),
    .escalated_reset_o       (escalated_reset_o)
  );

endmodule

`default_nettype wire

//--- tb/i3c_target_tb.sv
// Testbench for the I3C SDR target with a bus controller model and reference checks
`timescale 1ns/100ps
`default_nettype none

module i3c_target_tb;

  import i3c_target_pkg::*;

  logic        clk_i = 1'b0;
  logic        rst_ni = 1'b0;
  bus_state_t  bus_i = '0;
  addr_cfg_t   cfg_i = '0;
  logic        sda_o;
  logic        sel_od_pp_o;
  logic        rx_valid_o;
  rx_item_t    rx_item_o;
  logic        tx_valid_i = 1'b0;
  tx_item_t    tx_item_i = '0;
  logic        tx_ready_o;
  logic [7:0]  bus_addr_o;
  logic        bus_addr_valid_o;
  logic        peripheral_reset_o;
  logic        peripheral_reset_done_i = 1'b0;
  logic        escalated_reset_o;

  // Controller side of the bus
  logic        scl_q = 1'b1;
  logic        sda_drv_q = 1'b1;
  logic        start_q = 1'b0;
  logic        rstart_q = 1'b0;
  logic        stop_q = 1'b0;
  logic        prev_scl = 1'b1;
  logic        prev_sda = 1'b1;
  int unsigned seed = 74724;
  rx_item_t    rx_got[$];
  tx_item_t    tx_q[$];
  logic [6:0]  sta;
  logic [31:0] r;

  i3c_target_top i3c_target_top_inst (.*);

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return {16'h0, seed[31:16]};
  endfunction

  function automatic line_state_t line_of(input logic cur, input logic prev);
    return '{cur, cur & ~prev, ~cur & prev, cur & (cur == prev), ~cur & (cur == prev)};
  endfunction

  // SDA is wired-AND of controller and target
  always @(posedge clk_i) begin : bus_model
    logic line;
    line = sda_drv_q & sda_o;
    bus_i    <= '{start_q, rstart_q, stop_q, line_of(scl_q, prev_scl), line_of(line, prev_sda)};
    prev_scl <= scl_q;
    prev_sda <= line;
  end

  always @(posedge clk_i) begin
    if (rx_valid_o) rx_got.push_back(rx_item_o);
  end

  // Read stream source
  always @(posedge clk_i) begin
    if (tx_ready_o && tx_valid_i) void'(tx_q.pop_front());
    tx_valid_i <= (tx_q.size() > 0);
    tx_item_i  <= (tx_q.size() > 0) ? tx_q[0] : '0;
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Result: FAILED");
    $fatal(1, "timeout");
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  task automatic clock_bit(input logic drv, output logic seen);
    @(posedge clk_i) sda_drv_q <= drv;
    idle(3);
    @(posedge clk_i) scl_q <= 1'b1;
    idle(3);
    seen = bus_i.sda.value;
    @(posedge clk_i) scl_q <= 1'b0;
  endtask

  task automatic shift_byte(input logic [7:0] drv, output logic [7:0] seen);
    logic b;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(drv[i], b);
      seen[i] = b;
    end
  endtask

  task automatic send_start();
    @(posedge clk_i) begin
      sda_drv_q <= 1'b0;
      start_q   <= 1'b1;
    end
    @(posedge clk_i) start_q <= 1'b0;
    idle(3);
    @(posedge clk_i) scl_q <= 1'b0;
    idle(1);
  endtask

  task automatic send_stop();
    @(posedge clk_i) sda_drv_q <= 1'b0;
    idle(3);
    @(posedge clk_i) scl_q <= 1'b1;
    idle(3);
    @(posedge clk_i) begin
      sda_drv_q <= 1'b1;
      stop_q    <= 1'b1;
    end
    @(posedge clk_i) stop_q <= 1'b0;
    idle(4);
  endtask

  task automatic write_xfer(input logic [6:0] addr, input int n, input bit ack);
    logic       seen;
    logic [7:0] d;
    logic [7:0] dummy;
    logic       bad;
    rx_item_t   exp_q[$];
    int         cnt;
    rx_got.delete();
    send_start();
    shift_byte({addr, 1'b0}, dummy);
    clock_bit(1'b1, seen);
    check_value("ack_bit", 32'(!ack), 32'(seen));
    if (ack) check_value("bus_addr_o", 32'({addr, 1'b0}), 32'(bus_addr_o));
    for (int i = 0; i < n; i++) begin
      r   = next_rand();
      d   = r[7:0];
      r   = next_rand();
      // Second byte always carries a wrong T-bit
      bad = (i == 1) || (r[1:0] == 2'd0);
      shift_byte(d, dummy);
      // Odd parity over data and T-bit unless the byte is meant to be bad
      clock_bit(~^d ^ bad, seen);
      if (ack) exp_q.push_back(rx_item_t'{d, bad});
    end
    send_stop();
    cnt = 0;
    while (rx_got.size() < exp_q.size()) begin
      @(posedge clk_i);
      cnt++;
      if (cnt > 200) timeout_fail("received write bytes");
    end
    idle(10);
    check_value("rx_valid_o count", 32'(exp_q.size()), 32'(rx_got.size()));
    foreach (exp_q[i]) begin
      check_value("rx_item_o.data", 32'(exp_q[i].data), 32'(rx_got[i].data));
      check_value("rx_item_o.parity_err", 32'(exp_q[i].parity_err),
                  32'(rx_got[i].parity_err));
    end
  endtask

  task automatic read_xfer(input logic [6:0] addr, input int n);
    tx_item_t   exp_q[$];
    tx_item_t   it;
    logic [7:0] b;
    logic       seen;
    for (int i = 0; i < n; i++) begin
      r       = next_rand();
      it.data = r[7:0];
      it.last = (i == n - 1);
      exp_q.push_back(it);
      tx_q.push_back(it);
    end
    // One more item after the last must stay queued
    if (n > 0) begin
      r = next_rand();
      tx_q.push_back(tx_item_t'{r[7:0], 1'b0});
    end
    idle(2);
    send_start();
    shift_byte({addr, 1'b1}, b);
    clock_bit(1'b1, seen);
    check_value("ack_bit", 32'(n == 0), 32'(seen));
    if (n > 0) begin
      foreach (exp_q[i]) begin
        shift_byte(8'hff, b);
        check_value("read_data", 32'(exp_q[i].data), 32'(b));
        check_value("sel_od_pp_o", 32'd1, 32'(sel_od_pp_o));
        clock_bit(1'b1, seen);
        check_value("t_bit", 32'(!exp_q[i].last), 32'(seen));
      end
    end
    send_stop();
    if (n > 0) check_value("tx items left", 32'd1, 32'(tx_q.size()));
    tx_q.delete();
    idle(4);
  endtask

  task automatic send_reset_pattern();
    @(posedge clk_i) scl_q <= 1'b0;
    idle(2);
    repeat (ResetPatternEdges) begin
      @(posedge clk_i) sda_drv_q <= ~sda_drv_q;
      idle(1);
    end
    idle(3);
    @(posedge clk_i) scl_q <= 1'b1;
    idle(3);
    @(posedge clk_i) begin
      sda_drv_q <= 1'b0;
      rstart_q  <= 1'b1;
    end
    @(posedge clk_i) rstart_q <= 1'b0;
    idle(3);
    @(posedge clk_i) begin
      sda_drv_q <= 1'b1;
      stop_q    <= 1'b1;
    end
    @(posedge clk_i) stop_q <= 1'b0;
  endtask

  task automatic wait_reset_out(input bit esc);
    int cnt;
    cnt = 0;
    while (!(esc ? escalated_reset_o : peripheral_reset_o)) begin
      @(posedge clk_i);
      cnt++;
      if (cnt > 50) timeout_fail(esc ? "escalated reset" : "peripheral reset");
    end
  endtask

  task automatic ack_peripheral_reset();
    @(posedge clk_i) peripheral_reset_done_i <= 1'b1;
    @(posedge clk_i) peripheral_reset_done_i <= 1'b0;
    idle(2);
    check_value("peripheral_reset_o", 32'd0, 32'(peripheral_reset_o));
  endtask

  initial begin
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    idle(2);
    check_value("sda_o", 32'd1, 32'(sda_o));
    check_value("sel_od_pp_o", 32'd0, 32'(sel_od_pp_o));
    check_value("rx_valid_o", 32'd0, 32'(rx_valid_o));
    check_value("tx_ready_o", 32'd0, 32'(tx_ready_o));
    check_value("bus_addr_valid_o", 32'd0, 32'(bus_addr_valid_o));
    check_value("peripheral_reset_o", 32'd0, 32'(peripheral_reset_o));
    check_value("escalated_reset_o", 32'd0, 32'(escalated_reset_o));

    r   = next_rand();
    sta = r[6:0];
    @(posedge clk_i) cfg_i <= '{sta, 1'b1};
    write_xfer(sta, 4, 1'b1);
    write_xfer(sta, 6, 1'b1);
    write_xfer(sta ^ 7'h05, 2, 1'b0);
    @(posedge clk_i) cfg_i <= '{sta, 1'b0};
    write_xfer(sta, 2, 1'b0);
    @(posedge clk_i) cfg_i <= '{sta, 1'b1};

    read_xfer(sta, 0);
    r = next_rand();
    read_xfer(sta, 2 + int'(r[1:0]));
    read_xfer(sta, 1);

    send_reset_pattern();
    wait_reset_out(1'b0);
    check_value("escalated_reset_o", 32'd0, 32'(escalated_reset_o));
    ack_peripheral_reset();
    // A matched address disarms the monitor
    write_xfer(sta, 1, 1'b1);
    send_reset_pattern();
    wait_reset_out(1'b0);
    idle(4);
    check_value("escalated_reset_o", 32'd0, 32'(escalated_reset_o));
    ack_peripheral_reset();
    send_reset_pattern();
    wait_reset_out(1'b1);

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
common/i3c_target_pkg.sv
target/i3c_target_fsm.sv
hdl/bus_rx_flow.sv
hdl/bus_tx_flow.sv
hdl/target_reset_monitor.sv
hdl/i3c_target_top.sv
tb/i3c_target_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module i3c_target_tb \
  --Mdir obj_dir -o sim > build.log 2>&1

./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
grep -q "Result: PASSED" sim.log
